//--- design/psg_pkg.sv
// register index constants, level and sample widths, logarithmic level table
package psg_pkg;

    // ******************************
    // register map of the host port
    // ******************************

    // tone periods take a fine byte and a coarse nibble per channel
    localparam logic [4:0] reg_tone_a_fine   = 5'd0;
    localparam logic [4:0] reg_tone_a_coarse = 5'd1;
    localparam logic [4:0] reg_tone_b_fine   = 5'd2;
    localparam logic [4:0] reg_tone_b_coarse = 5'd3;
    localparam logic [4:0] reg_tone_c_fine   = 5'd4;
    localparam logic [4:0] reg_tone_c_coarse = 5'd5;
    localparam logic [4:0] reg_noise_period  = 5'd6;
    localparam logic [4:0] reg_mixer         = 5'd7;
    localparam logic [4:0] reg_amp_a         = 5'd8;
    localparam logic [4:0] reg_amp_b         = 5'd9;
    localparam logic [4:0] reg_amp_c         = 5'd10;
    localparam logic [4:0] reg_env_fine      = 5'd11;
    localparam logic [4:0] reg_env_coarse    = 5'd12;
    localparam logic [4:0] reg_env_shape     = 5'd13;
    // the two port registers are stored only
    localparam logic [4:0] reg_port_a        = 5'd14;
    localparam logic [4:0] reg_port_b        = 5'd15;

    // a channel level is a 4-bit index into the table below
    localparam int level_w = 4;
    // three channels of at most 181 fit in 10 bits
    localparam int audio_w = 10;

    // roughly 3 dB per level step, level 0 is silence
    localparam logic [7:0] level_table [16] = '{
        8'd0,  8'd1,  8'd2,  8'd3,  8'd4,  8'd6,   8'd8,   8'd11,
        8'd16, 8'd22, 8'd32, 8'd45, 8'd64, 8'd90,  8'd128, 8'd181
    };

endpackage

//--- design/ay_regs.sv
// host register file with address latch, readback and envelope restart strobe
`timescale 1ns/1ps

module ay_regs import psg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // low selects the address latch, high selects a data transfer
    input  logic       a0,
    // one clock wide, a0 and wdata are held stable while it is high
    input  logic       wr_tick,
    input  logic [7:0] wdata,
    // addressed register as it was one clock earlier
    output logic [7:0] rdata,

    output logic [7:0] r0,
    output logic [7:0] r1,
    output logic [7:0] r2,
    output logic [7:0] r3,
    output logic [7:0] r4,
    output logic [7:0] r5,
    output logic [7:0] r6,
    output logic [7:0] r7,
    output logic [7:0] r8,
    output logic [7:0] r9,
    output logic [7:0] r10,
    output logic [7:0] r11,
    output logic [7:0] r12,
    output logic [7:0] r13,
    // high for one clock right after the shape register takes a write
    output logic       env_restart
);

    // five address bits so that 16 to 31 can be decoded as out of range
    logic [4:0] addr;
    logic [7:0] regs [16];
    logic       data_wr;

    // a data write only lands when the latched address is below 16
    assign data_wr = wr_tick & a0 & ~addr[4];

    // ******************************
    // address latch and storage
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            addr        <= '0;
            rdata       <= '0;
            env_restart <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_tick & ~a0) begin
                addr <= wdata[4:0];
            end
            if (data_wr) begin
                regs[addr[3:0]] <= wdata;
            end

            // readback samples the array before this edge's write lands
            rdata <= addr[4] ? 8'h00 : regs[addr[3:0]];

            // the restart is raised on the same edge that stores the new shape
            env_restart <= data_wr & (addr == reg_env_shape);
        end
    end

    // ******************************
    // register outputs
    // ******************************

    assign r0  = regs[reg_tone_a_fine[3:0]];
    assign r1  = regs[reg_tone_a_coarse[3:0]];
    assign r2  = regs[reg_tone_b_fine[3:0]];
    assign r3  = regs[reg_tone_b_coarse[3:0]];
    assign r4  = regs[reg_tone_c_fine[3:0]];
    assign r5  = regs[reg_tone_c_coarse[3:0]];
    assign r6  = regs[reg_noise_period[3:0]];
    assign r7  = regs[reg_mixer[3:0]];
    assign r8  = regs[reg_amp_a[3:0]];
    assign r9  = regs[reg_amp_b[3:0]];
    assign r10 = regs[reg_amp_c[3:0]];
    assign r11 = regs[reg_env_fine[3:0]];
    assign r12 = regs[reg_env_coarse[3:0]];
    assign r13 = regs[reg_env_shape[3:0]];

endmodule

//--- design/psg_tone_bank.sv
// clock-enable prescaler and three square-wave tone counters
`timescale 1ns/1ps

module psg_tone_bank #(
    parameter int clk_div = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] r0,
    input  logic [7:0] r1,
    input  logic [7:0] r2,
    input  logic [7:0] r3,
    input  logic [7:0] r4,
    input  logic [7:0] r5,
    // one clock out of every clk_div
    output logic       tick,
    output logic       tone_a,
    output logic       tone_b,
    output logic       tone_c
);

    // a divide by one still needs a one-bit counter
    localparam int pre_w = (clk_div > 1) ? $clog2(clk_div) : 1;

    logic [pre_w-1:0] pre_cnt;
    logic [11:0]      period [3];
    logic [11:0]      tone_cnt [3];
    logic [2:0]       tone;

    assign tick = (pre_cnt == pre_w'(clk_div - 1));

    // coarse low nibble on top of the fine byte
    assign period[0] = {r1[3:0], r0};
    assign period[1] = {r3[3:0], r2};
    assign period[2] = {r5[3:0], r4};

    always_ff @(posedge clk) begin
        if (reset) begin
            pre_cnt <= '0;
            tone    <= '0;
            for (int ch = 0; ch < 3; ch++) begin
                tone_cnt[ch] <= '0;
            end
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                for (int ch = 0; ch < 3; ch++) begin
                    // a zero period acts as one, and >= catches a period that just shrank
                    if (period[ch] == '0 || tone_cnt[ch] >= period[ch] - 12'd1) begin
                        tone_cnt[ch] <= '0;
                        tone[ch]     <= ~tone[ch];
                    end else begin
                        tone_cnt[ch] <= tone_cnt[ch] + 12'd1;
                    end
                end
            end
        end
    end

    assign tone_a = tone[0];
    assign tone_b = tone[1];
    assign tone_c = tone[2];

endmodule

//--- design/psg_noise_gen.sv
// noise period counter and 17-bit shift-register noise source
`timescale 1ns/1ps

module psg_noise_gen (
    input  logic       clk,
    input  logic       reset,
    // generator clock enable from the tone bank prescaler
    input  logic       tick,
    // number of ticks between shifts, zero acts as one
    input  logic [4:0] noise_period,
    output logic       noise
);

    // ******************************
    // shift rate
    // ******************************

    logic [4:0]  rate_cnt;
    logic        shift_en;
    logic [16:0] lfsr;

    // the compare uses >= so a period written lower mid-count still wraps
    always_comb begin
        if (noise_period == '0) begin
            shift_en = tick;
        end else begin
            shift_en = tick && (rate_cnt >= noise_period - 5'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rate_cnt <= '0;
        end else if (shift_en) begin
            rate_cnt <= '0;
        end else if (tick) begin
            rate_cnt <= rate_cnt + 5'd1;
        end
    end

    // ******************************
    // noise source
    // ******************************

    // shifts right, feedback from bits 0 and 3 enters at the top
    // a seed of one keeps it out of the all-zero lockup state
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 17'd1;
        end else if (shift_en) begin
            lfsr <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
        end
    end

    assign noise = lfsr[0];

endmodule

//--- design/psg_envelope.sv
// envelope step counter and shape sequencer producing a 4-bit level
`timescale 1ns/1ps

module psg_envelope import psg_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    // generator clock enable from the tone bank prescaler
    input  logic               tick,
    // ticks per level step, zero acts as one
    input  logic [15:0]        env_period,
    // continue, attack, alternate, hold from bit 3 down
    input  logic [3:0]         shape,
    // restarts the shape from its first level
    input  logic               env_restart,
    output logic [level_w-1:0] env_level
);

    localparam logic [level_w-1:0] level_max = '1;

    logic [15:0]        step_cnt;
    logic [level_w-1:0] level;
    // direction of the current ramp, high while counting up
    logic               rising;
    // set once the shape has reached a level it keeps
    logic               stopped;
    logic               step_en;
    logic               ramp_end;
    logic               sh_continue;
    logic               sh_attack;
    logic               sh_alternate;
    logic               sh_hold;

    assign sh_continue  = shape[3];
    assign sh_attack    = shape[2];
    assign sh_alternate = shape[1];
    assign sh_hold      = shape[0];

    // one step per period of ticks, with a zero period taken as one
    assign step_en = tick && (env_period == '0 || step_cnt >= env_period - 16'd1);

    // the ramp is done when the level sits at the end it was heading for
    assign ramp_end = rising ? (level == level_max) : (level == '0);

    // ******************************
    // shape sequencer
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            step_cnt <= '0;
            level    <= '0;
            rising   <= 1'b0;
            stopped  <= 1'b0;
        end else if (env_restart) begin
            step_cnt <= '0;
            level    <= sh_attack ? '0 : level_max;
            rising   <= sh_attack;
            stopped  <= 1'b0;
        end else if (tick && !stopped) begin
            if (!step_en) begin
                step_cnt <= step_cnt + 16'd1;
            end else begin
                step_cnt <= '0;
                if (!ramp_end) begin
                    level <= rising ? level + 1'b1 : level - 1'b1;
                end else if (!sh_continue) begin
                    // single shot shapes fall silent after one ramp
                    level   <= '0;
                    stopped <= 1'b1;
                end else if (sh_hold) begin
                    level   <= sh_alternate ? ~level : level;
                    stopped <= 1'b1;
                end else if (sh_alternate) begin
                    // triangle, the end level is kept for one more step
                    rising <= ~rising;
                end else begin
                    // sawtooth, jump back to the start of the ramp
                    level <= rising ? '0 : level_max;
                end
            end
        end
    end

    assign env_level = level;

endmodule

//--- design/psg_mixer.sv
// per-channel tone/noise gating, amplitude selection, table lookup and sum
`timescale 1ns/1ps

module psg_mixer import psg_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               tone_a,
    input  logic               tone_b,
    input  logic               tone_c,
    input  logic               noise,
    // tone disables in bits 2..0, noise disables in bits 5..3
    input  logic [7:0]         mixer,
    // bit 4 selects the envelope, bits 3..0 are a fixed level
    input  logic [4:0]         amp_a,
    input  logic [4:0]         amp_b,
    input  logic [4:0]         amp_c,
    input  logic [level_w-1:0] env_level,
    output logic [audio_w-1:0] audio
);

    logic [2:0]         tone_bits;
    logic [4:0]         amp [3];
    logic [2:0]         chan_on;
    logic [level_w-1:0] level [3];
    logic [audio_w-1:0] sum;

    assign tone_bits = {tone_c, tone_b, tone_a};
    assign amp[0]    = amp_a;
    assign amp[1]    = amp_b;
    assign amp[2]    = amp_c;

    // ******************************
    // channel gating and level pick
    // ******************************

    // a disable bit forces its term true, so a fully disabled channel
    // gives a steady level that is useful as a plain DC output
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            chan_on[ch] = (tone_bits[ch] | mixer[ch]) & (noise | mixer[ch+3]);
            if (!chan_on[ch]) begin
                level[ch] = '0;
            end else if (amp[ch][4]) begin
                level[ch] = env_level;
            end else begin
                level[ch] = amp[ch][level_w-1:0];
            end
        end
    end

    // table entries are linear amplitudes, so the channels simply add
    always_comb begin
        sum = '0;
        for (int ch = 0; ch < 3; ch++) begin
            sum = sum + audio_w'(level_table[level[ch]]);
        end
    end

    // ******************************
    // output register
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            audio <= '0;
        end else begin
            audio <= sum;
        end
    end

endmodule

//--- design/psg_top.sv
// top level joining the register file, tone, noise and envelope generators and mixer
`timescale 1ns/1ps

module psg_top import psg_pkg::*; #(
    // clocks per generator tick
    parameter int clk_div = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               a0,
    input  logic               wr_tick,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata,
    output logic [audio_w-1:0] audio
);

    logic [7:0]         r0, r1, r2, r3, r4, r5, r6;
    logic [7:0]         r7, r8, r9, r10, r11, r12, r13;
    logic               env_restart;
    logic               tick;
    logic               tone_a;
    logic               tone_b;
    logic               tone_c;
    logic               noise;
    logic [level_w-1:0] env_level;

    // host side register file
    ay_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .a0          (a0),
        .wr_tick     (wr_tick),
        .wdata       (wdata),
        .rdata       (rdata),
        .r0          (r0),
        .r1          (r1),
        .r2          (r2),
        .r3          (r3),
        .r4          (r4),
        .r5          (r5),
        .r6          (r6),
        .r7          (r7),
        .r8          (r8),
        .r9          (r9),
        .r10         (r10),
        .r11         (r11),
        .r12         (r12),
        .r13         (r13),
        .env_restart (env_restart)
    );

    // the tone bank also owns the prescaler that paces the other generators
    psg_tone_bank #(
        .clk_div (clk_div)
    ) u_tone (
        .clk    (clk),
        .reset  (reset),
        .r0     (r0),
        .r1     (r1),
        .r2     (r2),
        .r3     (r3),
        .r4     (r4),
        .r5     (r5),
        .tick   (tick),
        .tone_a (tone_a),
        .tone_b (tone_b),
        .tone_c (tone_c)
    );

    psg_noise_gen u_noise (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .noise_period (r6[4:0]),
        .noise        (noise)
    );

    psg_envelope u_env (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .env_period  ({r12, r11}),
        .shape       (r13[3:0]),
        .env_restart (env_restart),
        .env_level   (env_level)
    );

    psg_mixer u_mixer (
        .clk       (clk),
        .reset     (reset),
        .tone_a    (tone_a),
        .tone_b    (tone_b),
        .tone_c    (tone_c),
        .noise     (noise),
        .mixer     (r7),
        .amp_a     (r8[4:0]),
        .amp_b     (r9[4:0]),
        .amp_c     (r10[4:0]),
        .env_level (env_level),
        .audio     (audio)
    );

endmodule

//--- dv/psg_tb.sv
// testbench for psg_top with bus tasks, a stimulus table, a watchdog and the result report
`timescale 1ns/1ps

module psg_tb import psg_pkg::*; ();

    localparam int clk_div      = 4;
    localparam int clk_period   = 10;
    localparam int reset_cycles = 16;

    // ******************************
    // waits per row kind in clocks
    // ******************************

    localparam int audio_delay  = 3;
    localparam int tone_settle  = 64;
    // a multiple of every tone half period used below
    localparam int tone_window  = 384;
    // sixteen envelope steps of four clocks plus some slack
    localparam int env_wait     = 17 * 4 + 16;
    localparam int restart_wait = 4;
    localparam int noise_limit  = 200;
    localparam int margin       = 300;

    // write only, readback, fixed audio, tone rate, envelope end level,
    // envelope restart and noise activity
    localparam logic [3:0] k_write   = 4'd0;
    localparam logic [3:0] k_read    = 4'd1;
    localparam logic [3:0] k_audio   = 4'd2;
    localparam logic [3:0] k_tone    = 4'd3;
    localparam logic [3:0] k_env     = 4'd4;
    localparam logic [3:0] k_restart = 4'd5;
    localparam logic [3:0] k_noise   = 4'd6;

    typedef struct packed {
        logic [3:0]  kind;
        logic [4:0]  addr;
        logic [7:0]  value;
        logic [15:0] expected;
    } row_t;

    logic               clk;
    logic               reset;
    logic               a0;
    logic               wr_tick;
    logic [7:0]         wdata;
    logic [7:0]         rdata;
    logic [audio_w-1:0] audio;

    row_t       rows[$];
    // the values the host believes it wrote
    logic [7:0] shadow [16];
    int         error_count;
    int         watchdog_clocks;
    logic       table_ready;

    psg_top #(
        .clk_div (clk_div)
    ) uut (
        .clk     (clk),
        .reset   (reset),
        .a0      (a0),
        .wr_tick (wr_tick),
        .wdata   (wdata),
        .rdata   (rdata),
        .audio   (audio)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // the limit is known only once the table has been built
    initial begin
        wait (table_ready);
        #(watchdog_clocks * clk_period);
        $display("watchdog expired after %0d clocks, the run did not finish", watchdog_clocks);
        $display("Test failures found");
        $finish;
    end

    // ******************************
    // host bus tasks
    // ******************************

    // every task is entered and left 1 ns after a rising edge
    task automatic write_addr(input logic [4:0] addr);
        a0      = 1'b0;
        wdata   = {3'b000, addr};
        wr_tick = 1'b1;
        @(posedge clk);
        #1;
        wr_tick = 1'b0;
    endtask

    task automatic write_data(input logic [7:0] value);
        a0      = 1'b1;
        wdata   = value;
        wr_tick = 1'b1;
        @(posedge clk);
        #1;
        wr_tick = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [7:0] value);
        write_addr(addr);
        write_data(value);
    endtask

    // rdata follows the new address one edge after the latching edge
    task automatic read_reg(input logic [4:0] addr, output logic [7:0] data);
        write_addr(addr);
        @(posedge clk);
        #1;
        data = rdata;
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Fail: time %0t, %s expected %0d actual %0d", $time, name, expected, actual);
        error_count++;
    endtask

    // ******************************
    // stimulus table
    // ******************************

    task automatic add_row(input logic [3:0] kind, input logic [4:0] addr,
                           input logic [7:0] value, input int expected);
        row_t r;
        r.kind     = kind;
        r.addr     = addr;
        r.value    = value;
        r.expected = 16'(expected);
        rows.push_back(r);
    endtask

    // a tone output toggles once per max(p,1) ticks and each toggle moves audio
    function automatic int toggles_in_window(input int period);
        int eff;
        eff = (period == 0) ? 1 : period;
        return tone_window / (clk_div * eff);
    endfunction

    function automatic int row_budget(input logic [3:0] kind);
        case (kind)
            k_audio:   return 2 + audio_delay;
            k_tone:    return 2 + tone_settle + tone_window;
            k_env:     return 2 + env_wait;
            k_restart: return 2 + restart_wait;
            k_noise:   return 2 + noise_limit;
            default:   return 2;
        endcase
    endfunction

    task automatic build_table();
        // mixer readback, then all channels on for fixed levels
        add_row(k_write, reg_mixer, 8'h3F, 0);
        add_row(k_read,  reg_mixer, 8'h00, 8'h3F);
        add_row(k_write, reg_amp_a, 8'd15, 0);
        add_row(k_write, reg_amp_b, 8'd15, 0);
        add_row(k_audio, reg_amp_c, 8'd15, 3 * int'(level_table[15]));
        add_row(k_write, reg_amp_a, 8'd8, 0);
        add_row(k_write, reg_amp_b, 8'd12, 0);
        add_row(k_audio, reg_amp_c, 8'd3,
                int'(level_table[8]) + int'(level_table[12]) + int'(level_table[3]));
        add_row(k_write, reg_amp_a, 8'd1, 0);
        add_row(k_write, reg_amp_b, 8'd9, 0);
        add_row(k_audio, reg_amp_c, 8'd14,
                int'(level_table[1]) + int'(level_table[9]) + int'(level_table[14]));
        add_row(k_write, reg_amp_a, 8'd10, 0);
        add_row(k_write, reg_amp_b, 8'd11, 0);
        add_row(k_audio, reg_amp_c, 8'd13,
                int'(level_table[10]) + int'(level_table[11]) + int'(level_table[13]));
        add_row(k_write, reg_amp_a, 8'd0, 0);
        add_row(k_write, reg_amp_b, 8'd0, 0);
        add_row(k_audio, reg_amp_c, 8'd0, 0);
        // tone A alone, noise terms forced on, B and C silent
        add_row(k_write, reg_mixer, 8'h3E, 0);
        add_row(k_write, reg_amp_a, 8'd15, 0);
        add_row(k_write, reg_tone_a_coarse, 8'd0, 0);
        add_row(k_tone,  reg_tone_a_fine, 8'd0, toggles_in_window(0));
        add_row(k_tone,  reg_tone_a_fine, 8'd1, toggles_in_window(1));
        add_row(k_tone,  reg_tone_a_fine, 8'd2, toggles_in_window(2));
        add_row(k_tone,  reg_tone_a_fine, 8'd3, toggles_in_window(3));
        add_row(k_tone,  reg_tone_a_fine, 8'd6, toggles_in_window(6));
        // noise only on channel A
        add_row(k_write, reg_mixer, 8'h37, 0);
        add_row(k_noise, reg_noise_period, 8'd1, int'(level_table[15]));
        // channel A follows the envelope, which steps on every tick
        add_row(k_write, reg_mixer, 8'h3F, 0);
        add_row(k_write, reg_amp_a, 8'h10, 0);
        add_row(k_read,  reg_amp_a, 8'h00, 8'h10);
        add_row(k_write, reg_env_fine, 8'd1, 0);
        add_row(k_write, reg_env_coarse, 8'd0, 0);
        add_row(k_env,   reg_env_shape, 8'h09, 0);
        add_row(k_env,   reg_env_shape, 8'h0F, 0);
        add_row(k_env,   reg_env_shape, 8'h0D, int'(level_table[15]));
        // rewriting the shape must pull audio off the held top level
        add_row(k_restart, reg_env_shape, 8'h0D, int'(level_table[15]));
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        row_t               row;
        logic [7:0]         got;
        int                 changes;
        int                 want;
        int                 n;
        logic [audio_w-1:0] prev;
        logic               seen_low;
        logic               seen_high;

        reset       = 1'b1;
        a0          = 1'b0;
        wr_tick     = 1'b0;
        wdata       = 8'h00;
        error_count = 0;
        table_ready = 1'b0;
        void'($urandom(32'h8113));

        build_table();
        // reset, sixteen reset reads, random writes and reads, the address 20 pair and a recheck
        watchdog_clocks = margin + reset_cycles + 16 * 2 + 16 * 4 + 8;
        foreach (rows[i]) begin
            watchdog_clocks += row_budget(rows[i].kind);
        end
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // nothing has been written yet, so everything must read back as zero
        if (audio !== '0) report_mismatch("audio", 0, int'(audio));
        for (int i = 0; i < 16; i++) begin
            read_reg(5'(i), got);
            if (got !== 8'h00) report_mismatch($sformatf("rdata of register %0d", i), 0, int'(got));
        end

        // random bytes into every register, then read them all back
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 8'($urandom);
            write_reg(5'(i), shadow[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_reg(5'(i), got);
            if (got !== shadow[i]) begin
                report_mismatch($sformatf("rdata of register %0d", i), int'(shadow[i]), int'(got));
            end
        end
        // out of range addresses drop the write and read as zero
        write_reg(5'd20, ~shadow[4]);
        read_reg(5'd20, got);
        if (got !== 8'h00) report_mismatch("rdata of address 20", 0, int'(got));
        // address 20 shares its low bits with register 4, which keeps its value
        read_reg(5'd4, got);
        if (got !== shadow[4]) report_mismatch("rdata of register 4", int'(shadow[4]), int'(got));

        foreach (rows[i]) begin
            row = rows[i];
            case (row.kind)
                k_write: begin
                    write_reg(row.addr, row.value);
                end
                k_read: begin
                    read_reg(row.addr, got);
                    if (got !== row.expected[7:0]) begin
                        report_mismatch($sformatf("rdata of register %0d", row.addr),
                                        int'(row.expected), int'(got));
                    end
                end
                k_audio: begin
                    write_reg(row.addr, row.value);
                    repeat (audio_delay) @(posedge clk);
                    #1;
                    if (audio !== audio_w'(row.expected)) begin
                        report_mismatch("audio", int'(row.expected), int'(audio));
                    end
                end
                k_tone: begin
                    write_reg(row.addr, row.value);
                    repeat (tone_settle) @(posedge clk);
                    #1;
                    changes = 0;
                    prev    = audio;
                    repeat (tone_window) begin
                        @(posedge clk);
                        #1;
                        if (audio !== prev) changes++;
                        prev = audio;
                    end
                    want = int'(row.expected);
                    // the window phase may add or drop one toggle
                    if (changes > want + 1 || changes < want - 1) begin
                        report_mismatch($sformatf("audio changes for tone period %0d", row.value),
                                        want, changes);
                    end
                end
                k_env: begin
                    write_reg(row.addr, row.value);
                    repeat (env_wait) @(posedge clk);
                    #1;
                    if (audio !== audio_w'(row.expected)) begin
                        report_mismatch($sformatf("audio for envelope shape %0d", row.value),
                                        int'(row.expected), int'(audio));
                    end
                end
                k_restart: begin
                    write_reg(row.addr, row.value);
                    repeat (restart_wait) @(posedge clk);
                    #1;
                    if (audio === audio_w'(row.expected)) begin
                        $display("rewriting envelope shape %0d did not restart it, audio stayed at %0d",
                                 row.value, audio);
                        error_count++;
                    end
                end
                k_noise: begin
                    write_reg(row.addr, row.value);
                    seen_low  = 1'b0;
                    seen_high = 1'b0;
                    n         = 0;
                    while (!(seen_low && seen_high) && n < noise_limit) begin
                        @(posedge clk);
                        #1;
                        if (audio == '0) seen_low = 1'b1;
                        if (audio == audio_w'(row.expected)) seen_high = 1'b1;
                        n++;
                    end
                    if (!(seen_low && seen_high)) begin
                        $display("noise did not move audio between 0 and %0d within %0d clocks",
                                 row.expected, noise_limit);
                        error_count++;
                    end
                end
                default: begin
                    $display("the stimulus table holds an unknown row kind %0d", row.kind);
                    error_count++;
                end
            endcase
        end

        $display("%0d table rows applied, %0d errors", rows.size(), error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- all.f
design/psg_pkg.sv
design/ay_regs.sv
design/psg_tone_bank.sv
design/psg_noise_gen.sv
design/psg_envelope.sv
design/psg_mixer.sv
design/psg_top.sv
dv/psg_tb.sv

//--- run.sh
#!/bin/sh
# build the sound generator and its testbench with verilator, run it, check the log
set -e

cd "$(dirname "$0")"

build=obj_dir
log=sim.log

rm -rf "$build" "$log"

verilator --binary --timing -sv \
    --top-module psg_tb \
    --Mdir "$build" \
    -o psg_sim \
    -f all.f

"./$build/psg_sim" | tee "$log"

if grep -q "All tests passed!" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
